// File: src/lcdPkg.sv
////////////////////////////////////////////////////////////////////////////
// lcd side definitions
// character buffer types, HD44780 command opcodes, hold-wait classes
// and the LCD pin bundle
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package lcdPkg;

    typedef logic [4:0] charAddrT;  // 32 positions, two lines of 16
    typedef logic [7:0] charCodeT;

    // opcodes sent with rs low
    typedef enum logic [7:0] {
        cmdFunctionSet  = 8'h38,    // 8-bit bus, two lines, 5x8 font
        cmdDisplayOff   = 8'h08,
        cmdDisplayClear = 8'h01,
        cmdEntryMode    = 8'h06,    // increment, no shift
        cmdDisplayOn    = 8'h0C,
        cmdSetDdram     = 8'h80,    // line one base
        lineTwoBase     = 8'hC0
    } lcdCmdE;

    // hold wait after the enable pulse
    typedef enum logic [1:0] {
        waitChar,
        waitCmd,
        waitLong
    } waitSelE;

    typedef struct packed {
        logic     valid;
        charAddrT addr;
        charCodeT code;
    } charWriteT;

    typedef struct packed {
        logic       valid;
        logic       rs;     // 0 command, 1 data
        logic [7:0] data;
        waitSelE    waitSel;
    } lcdCycleT;

    typedef struct packed {
        logic       rs;
        logic       en;
        logic [7:0] data;
    } lcdPinsT;

endpackage

`default_nettype wire

// File: src/hostPkg.sv
////////////////////////////////////////////////////////////////////////////
// host side definitions
// AXI4-Lite write channel request and response bundles plus the
// response codes and the size of the character region
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package hostPkg;

    // inputs of the write channel as seen by the slave
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [15:0] wdata;     // character in bits 7:0
        logic [1:0]  wstrb;
        logic        bready;
    } axiWrReqT;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axiWrRespT;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    localparam int charRegionBytes = 128;   // 32 word-aligned slots

endpackage

`default_nettype wire

// File: src/charWriteSlave.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite write-only slave
// accepts address and data beats independently, range checks the
// address, issues one buffer write and holds the response until bready
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module charWriteSlave
(
    input  wire logic              clk,
    input  wire logic              lcdOnIn,
    input  wire hostPkg::axiWrReqT axiReq,
    output hostPkg::axiWrRespT     axiResp,
    output lcdPkg::charWriteT      charWrite
);

    logic       awHeld;     // address beat captured
    logic       wHeld;      // data beat captured
    logic       bValid;
    logic [1:0] bResp;
    logic       writeValid;

    logic [7:0]       addrReg;
    lcdPkg::charCodeT codeReg;
    logic             strbReg;

    logic awReady;
    logic wReady;
    logic inRange;
    logic bothHeld;

    // only one write outstanding
    assign awReady  = !awHeld && !bValid;
    assign wReady   = !wHeld && !bValid;
    assign inRange  = addrReg < hostPkg::charRegionBytes;
    assign bothHeld = awHeld && wHeld;

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            awHeld     <= 1'b0;
            wHeld      <= 1'b0;
            bValid     <= 1'b0;
            bResp      <= hostPkg::respOkay;
            writeValid <= 1'b0;
        end
        else
        begin
            writeValid <= 1'b0;     // single cycle pulse
            if (awReady && axiReq.awvalid)
            begin
                awHeld <= 1'b1;
            end
            if (wReady && axiReq.wvalid)
            begin
                wHeld <= 1'b1;
            end
            if (bothHeld)
            begin
                awHeld     <= 1'b0;
                wHeld      <= 1'b0;
                bValid     <= 1'b1;
                bResp      <= inRange ? hostPkg::respOkay : hostPkg::respSlvErr;
                writeValid <= inRange && strbReg;   // low byte lane only
            end
            else if (bValid && axiReq.bready)
            begin
                bValid <= 1'b0;
            end
        end
    end

    // beat payload, stable until the response is taken
    always_ff @(posedge clk)
    begin
        if (awReady && axiReq.awvalid)
        begin
            addrReg <= axiReq.awaddr;
        end
        if (wReady && axiReq.wvalid)
        begin
            codeReg <= axiReq.wdata[7:0];
            strbReg <= axiReq.wstrb[0];
        end
    end

    assign axiResp   = '{awready: awReady, wready: wReady, bvalid: bValid, bresp: bResp};
    assign charWrite = '{valid: writeValid, addr: addrReg[6:2], code: codeReg};

endmodule

`default_nettype wire

// File: src/charBuffer.sv
////////////////////////////////////////////////////////////////////////////
// character buffer
// 32 x 8 store, one write port from the host side and a read port
// that is registered on every clock
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module charBuffer
(
    input  wire logic              clk,
    input  wire logic              lcdOnIn,
    input  wire lcdPkg::charWriteT charWrite,
    input  wire lcdPkg::charAddrT  readAddr,
    output lcdPkg::charCodeT       readCode
);

    lcdPkg::charCodeT mem [32];

    always_ff @(posedge clk)
    begin
        if (charWrite.valid)
        begin
            mem[charWrite.addr] <= charWrite.code;
        end
    end

    // one clock read latency
    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            readCode <= '0;
        end
        else
        begin
            readCode <= mem[readAddr];
        end
    end

endmodule

`default_nettype wire

// File: src/lcdSequencer.sv
////////////////////////////////////////////////////////////////////////////
// LCD sequencer
// power-on wait, eight init commands, then an endless refresh of all
// 32 positions as address and data transfer pairs
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdSequencer
#(
    parameter int powerOnCycles = 1000000
)
(
    input  wire logic             clk,
    input  wire logic             lcdOnIn,
    input  wire lcdPkg::charCodeT readCode,
    input  wire logic             cycleReady,
    output lcdPkg::charAddrT      readAddr,
    output lcdPkg::lcdCycleT      cycleReq
);

    localparam int waitW = $clog2(powerOnCycles + 1);

    typedef enum logic [1:0] {
        powerOn,
        initCmd,
        refreshAddr,
        refreshData
    } seqStateE;

    seqStateE         state;
    logic [waitW-1:0] waitCnt;
    logic [2:0]       initIdx;
    lcdPkg::charAddrT pos;
    logic             reqValid;

    logic           reqRs;
    logic [7:0]     reqData;
    lcdPkg::waitSelE reqWait;

    logic            loadReq;
    logic            reqAccept;
    logic [7:0]      ddramCmd;
    logic [7:0]      initCode;
    lcdPkg::waitSelE initWait;
    logic            nextRs;
    logic [7:0]      nextData;
    lcdPkg::waitSelE nextWait;

    assign loadReq   = !reqValid && (state != powerOn);
    assign reqAccept = reqValid && cycleReady;

    // second line starts at DDRAM 0x40
    assign ddramCmd = pos[4] ? (lcdPkg::lineTwoBase | {4'h0, pos[3:0]})
                             : (lcdPkg::cmdSetDdram | {4'h0, pos[3:0]});

    always_comb
    begin
        initWait = lcdPkg::waitCmd;
        case (initIdx)
            3'd0:
            begin
                initCode = lcdPkg::cmdFunctionSet;
                initWait = lcdPkg::waitLong;    // first one needs the long wait
            end
            3'd1, 3'd2, 3'd3: initCode = lcdPkg::cmdFunctionSet;
            3'd4:             initCode = lcdPkg::cmdDisplayOff;
            3'd5:
            begin
                initCode = lcdPkg::cmdDisplayClear;
                initWait = lcdPkg::waitLong;
            end
            3'd6:             initCode = lcdPkg::cmdEntryMode;
            default:          initCode = lcdPkg::cmdDisplayOn;
        endcase
    end

    always_comb
    begin
        nextRs   = 1'b0;
        nextData = ddramCmd;
        nextWait = lcdPkg::waitChar;
        case (state)
            initCmd:
            begin
                nextData = initCode;
                nextWait = initWait;
            end
            refreshData:
            begin
                nextRs   = 1'b1;
                nextData = readCode;    // read at the address accept
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            state    <= powerOn;
            waitCnt  <= '0;
            initIdx  <= '0;
            pos      <= '0;
            reqValid <= 1'b0;
        end
        else
        begin
            if (loadReq)
            begin
                reqValid <= 1'b1;
            end
            else if (reqAccept)
            begin
                reqValid <= 1'b0;
            end

            case (state)
                powerOn:
                begin
                    if (waitCnt == waitW'(powerOnCycles - 1))
                    begin
                        state <= initCmd;
                    end
                    else
                    begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                initCmd:
                begin
                    if (reqAccept)
                    begin
                        if (initIdx == 3'd7)
                        begin
                            state <= refreshAddr;
                        end
                        initIdx <= initIdx + 1'b1;
                    end
                end
                refreshAddr:
                begin
                    if (reqAccept)
                    begin
                        state <= refreshData;
                    end
                end
                default:
                begin
                    if (reqAccept)
                    begin
                        pos   <= pos + 1'b1;   // wraps 31 -> 0
                        state <= refreshAddr;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (loadReq)
        begin
            reqRs   <= nextRs;
            reqData <= nextData;
            reqWait <= nextWait;
        end
    end

    assign readAddr = pos;
    assign cycleReq = '{valid: reqValid, rs: reqRs, data: reqData, waitSel: reqWait};

endmodule

`default_nettype wire

// File: src/lcdBusCycle.sv
////////////////////////////////////////////////////////////////////////////
// LCD bus cycle
// runs one transfer as setup, enable pulse and hold wait, and drives
// the rs, en and data pins
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdBusCycle
#(
    parameter int enableCycles   = 26,
    parameter int charWaitCycles = 26,
    parameter int cmdWaitCycles  = 7500,
    parameter int longWaitCycles = 250000
)
(
    input  wire logic             clk,
    input  wire logic             lcdOnIn,
    input  wire lcdPkg::lcdCycleT cycleReq,
    output logic                  cycleReady,
    output lcdPkg::lcdPinsT       lcdPins
);

    // wide enough for the largest load
    localparam int cntW =
        $clog2(enableCycles + charWaitCycles + cmdWaitCycles + longWaitCycles + 1);

    typedef enum logic [1:0] {
        idle,
        setup,
        strobe,
        hold
    } phaseE;

    phaseE           phase;
    logic [cntW-1:0] count;
    logic [cntW-1:0] holdLoad;
    logic            busy;

    logic            rsReg;
    logic [7:0]      dataReg;
    lcdPkg::waitSelE waitReg;

    always_comb
    begin
        case (waitReg)
            lcdPkg::waitChar: holdLoad = cntW'(charWaitCycles - 1);
            lcdPkg::waitCmd:  holdLoad = cntW'(cmdWaitCycles - 1);
            default:          holdLoad = cntW'(longWaitCycles - 1);
        endcase
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            phase <= idle;
            count <= '0;
        end
        else
        begin
            case (phase)
                idle:
                begin
                    if (cycleReq.valid)
                    begin
                        phase <= setup;
                    end
                end
                setup:
                begin
                    phase <= strobe;
                    count <= cntW'(enableCycles - 1);
                end
                strobe:
                begin
                    if (count == '0)
                    begin
                        phase <= hold;
                        count <= holdLoad;
                    end
                    else
                    begin
                        count <= count - 1'b1;
                    end
                end
                default:
                begin
                    if (count == '0)
                    begin
                        phase <= idle;
                    end
                    else
                    begin
                        count <= count - 1'b1;
                    end
                end
            endcase
        end
    end

    // transfer captured on the accepting edge
    always_ff @(posedge clk)
    begin
        if (cycleReady && cycleReq.valid)
        begin
            rsReg   <= cycleReq.rs;
            dataReg <= cycleReq.data;
            waitReg <= cycleReq.waitSel;
        end
    end

    assign cycleReady = (phase == idle);
    assign busy       = !cycleReady;
    assign lcdPins    = '{rs: busy && rsReg,
                          en: phase == strobe,
                          data: busy ? dataReg : 8'h00};  // bus parked at zero

endmodule

`default_nettype wire

// File: src/lcdController.sv
////////////////////////////////////////////////////////////////////////////
// LCD controller top
// host write slave feeding the character buffer, read back by the
// sequencer which drives the LCD through the bus cycle unit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdController
#(
    parameter int powerOnCycles  = 1000000,  // 20 ms at 50 MHz
    parameter int enableCycles   = 26,
    parameter int charWaitCycles = 26,
    parameter int cmdWaitCycles  = 7500,
    parameter int longWaitCycles = 250000
)
(
    input  wire logic              clk,
    input  wire logic              lcdOnIn,
    input  wire hostPkg::axiWrReqT axiReq,
    output hostPkg::axiWrRespT     axiResp,
    output lcdPkg::lcdPinsT        lcdPins
);

    lcdPkg::charWriteT charWrite;
    lcdPkg::charAddrT  readAddr;
    lcdPkg::charCodeT  readCode;
    lcdPkg::lcdCycleT  cycleReq;
    logic              cycleReady;

    charWriteSlave i_slave
    (
        .clk       (clk),
        .lcdOnIn   (lcdOnIn),
        .axiReq    (axiReq),
        .axiResp   (axiResp),
        .charWrite (charWrite)
    );

    charBuffer i_buffer
    (
        .clk       (clk),
        .lcdOnIn   (lcdOnIn),
        .charWrite (charWrite),
        .readAddr  (readAddr),
        .readCode  (readCode)
    );

    lcdSequencer #(
        .powerOnCycles (powerOnCycles)
    ) i_sequencer (
        .clk        (clk),
        .lcdOnIn    (lcdOnIn),
        .readCode   (readCode),
        .cycleReady (cycleReady),
        .readAddr   (readAddr),
        .cycleReq   (cycleReq)
    );

    lcdBusCycle #(
        .enableCycles   (enableCycles),
        .charWaitCycles (charWaitCycles),
        .cmdWaitCycles  (cmdWaitCycles),
        .longWaitCycles (longWaitCycles)
    ) i_busCycle (
        .clk        (clk),
        .lcdOnIn    (lcdOnIn),
        .cycleReq   (cycleReq),
        .cycleReady (cycleReady),
        .lcdPins    (lcdPins)
    );

endmodule

`default_nettype wire

// File: sim/tbClock.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock
// free running clock, 8 ns period
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbClock
#(
    parameter int periodNs = 8
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: sim/lcdController_assertions.sv
////////////////////////////////////////////////////////////////////////////
// LCD controller assertions
// strobe stability on the LCD pins and AXI write response rules
// for every bound lcdController instance
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdControllerAssertions
(
    input wire logic               clk,
    input wire logic               lcdOnIn,
    input wire hostPkg::axiWrReqT  axiReq,
    input wire hostPkg::axiWrRespT axiResp,
    input wire lcdPkg::lcdPinsT    lcdPins
);

    int failCount = 0;  // failed properties so far

    // rs and data frozen for the whole enable pulse
    pinsStableInStrobe: assert property (@(posedge clk) disable iff (!lcdOnIn)
        lcdPins.en && $past(lcdPins.en) |-> $stable(lcdPins.rs) && $stable(lcdPins.data))
    else
    begin
        failCount++;
        $error("rs or data changed while en was high");
    end

    // response held until the host takes it
    respHeld: assert property (@(posedge clk) disable iff (!lcdOnIn)
        axiResp.bvalid && !axiReq.bready |=> axiResp.bvalid && $stable(axiResp.bresp))
    else
    begin
        failCount++;
        $error("bvalid or bresp changed before bready");
    end

    // one write outstanding
    noAcceptDuringResp: assert property (@(posedge clk) disable iff (!lcdOnIn)
        axiResp.bvalid |-> !axiResp.awready && !axiResp.wready)
    else
    begin
        failCount++;
        $error("slave ready for a new beat while a response is pending");
    end

endmodule

bind lcdController lcdControllerAssertions i_assertions
(
    .clk     (clk),
    .lcdOnIn (lcdOnIn),
    .axiReq  (axiReq),
    .axiResp (axiResp),
    .lcdPins (lcdPins)
);

`default_nettype wire

// File: sim/lcdControllerTb.sv
////////////////////////////////////////////////////////////////////////////
// LCD controller testbench
// host writes over AXI4-Lite, a monitor on the LCD bus that checks
// every strobe against a reference model of the sequencer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdControllerTb;

    localparam int powerOnCycles  = 40;
    localparam int enableCycles   = 4;
    localparam int charWaitCycles = 3;
    localparam int cmdWaitCycles  = 6;
    localparam int longWaitCycles = 12;

    localparam logic [1:0] okayResp   = 2'b00;
    localparam logic [1:0] slvErrResp = 2'b10;

    logic               clk;
    logic               lcdOnIn;
    hostPkg::axiWrReqT  axiReq;
    hostPkg::axiWrRespT axiResp;
    lcdPkg::lcdPinsT    lcdPins;

    integer     seed = 77482;
    logic [7:0] shadow [32];    // expected buffer contents
    logic [7:0] prevCode [32];  // value before the last rewrite
    int         grace [32];     // visits the old value may still show

    int   strobeIdx = 0;
    int   highCount = 0;
    int   idleCount = 0;
    logic enSeen = 1'b0;

    tbClock #(.periodNs(8)) i_clock (.clk(clk));

    lcdController #(
        .powerOnCycles  (powerOnCycles),
        .enableCycles   (enableCycles),
        .charWaitCycles (charWaitCycles),
        .cmdWaitCycles  (cmdWaitCycles),
        .longWaitCycles (longWaitCycles)
    ) i_dut (
        .clk     (clk),
        .lcdOnIn (lcdOnIn),
        .axiReq  (axiReq),
        .axiResp (axiResp),
        .lcdPins (lcdPins)
    );

    function automatic int nextRandom();
        return $random(seed);
    endfunction

    // {rs, data} of strobe idx counted from reset
    function automatic logic [8:0] expectedByte(input int idx, input logic [7:0] codes [32]);
        int         k;
        int         pos;
        logic [8:0] result;
        if (idx < 8)
        begin
            case (idx)
                0, 1, 2, 3: result = {1'b0, 8'h38};
                4:          result = {1'b0, 8'h08};
                5:          result = {1'b0, 8'h01};
                6:          result = {1'b0, 8'h06};
                default:    result = {1'b0, 8'h0C};
            endcase
        end
        else
        begin
            k   = idx - 8;
            pos = (k / 2) % 32;
            if (k % 2 == 1)
            begin
                result = {1'b1, codes[pos]};
            end
            else if (pos < 16)
            begin
                result = {1'b0, 8'h80 + 8'(pos)};
            end
            else
            begin
                result = {1'b0, 8'hC0 + 8'(pos - 16)};
            end
        end
        return result;
    endfunction

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            stopOnError($sformatf("Error: %s expected %0h actual %0h",
                                  testName, expected, actual));
        end
    endtask

    task automatic compareStrobe();
        logic [8:0] expected;
        logic [8:0] actual;
        int         pos;
        expected = expectedByte(strobeIdx, shadow);
        actual   = {lcdPins.rs, lcdPins.data};
        pos      = (strobeIdx >= 8) ? ((strobeIdx - 8) / 2) % 32 : 0;
        if (expected[8] && actual != expected && grace[pos] > 0
            && actual == {1'b1, prevCode[pos]})
        begin
            expected = {1'b1, prevCode[pos]};   // read before the rewrite landed
            grace[pos]--;
        end
        else if (expected[8])
        begin
            grace[pos] = 0;
        end
        checkValue($sformatf("strobe %0d", strobeIdx), expected, actual);
        strobeIdx++;
    endtask

    // LCD bus monitor samples the pins as they stood before each edge
    always @(posedge clk)
    begin
        if (!lcdOnIn)
        begin
            strobeIdx = 0;
            highCount = 0;
            idleCount = 0;
            enSeen    = 1'b0;
        end
        else
        begin
            if (lcdPins.en && !enSeen)
            begin
                compareStrobe();
            end
            if (lcdPins.en)
            begin
                highCount++;
                idleCount = 0;
            end
            else
            begin
                if (enSeen)
                begin
                    checkValue("strobe width", enableCycles, highCount);
                end
                highCount = 0;
                idleCount++;
                if (idleCount > 400)
                begin
                    stopOnError("LCD enable stayed low for too long");
                end
            end
            enSeen = lcdPins.en;
        end
    end

    // failures of the bound assertions
    always @(negedge clk)
    begin
        if (i_dut.i_assertions.failCount != 0)
        begin
            stopOnError("an assertion bound to the DUT failed");
        end
    end

    task automatic sendBeats(input logic [7:0] addr, input logic [7:0] code,
                             input logic [1:0] strb);
        int   cycles;
        logic awGo;
        logic wGo;
        @(negedge clk);
        axiReq.awvalid = 1'b1;
        axiReq.awaddr  = addr;
        axiReq.wvalid  = 1'b1;
        axiReq.wdata   = {8'(nextRandom()), code};
        axiReq.wstrb   = strb;
        axiReq.bready  = 1'b0;
        cycles = 0;
        while (axiReq.awvalid || axiReq.wvalid)
        begin
            awGo = axiReq.awvalid && axiResp.awready;   // transfers on the next edge
            wGo  = axiReq.wvalid && axiResp.wready;
            @(negedge clk);
            if (awGo)
            begin
                axiReq.awvalid = 1'b0;
            end
            if (wGo)
            begin
                axiReq.wvalid = 1'b0;
            end
            cycles++;
            if (cycles > 50)
            begin
                stopOnError("slave did not accept the address or data beat");
            end
        end
    endtask

    task automatic awaitResponse();
        int cycles;
        cycles = 0;
        while (!axiResp.bvalid)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 50)
            begin
                stopOnError("no write response from the slave");
            end
        end
    endtask

    task automatic writeChar(input logic [7:0] addr, input logic [7:0] code,
                             input logic [1:0] strb);
        logic [1:0] expResp;
        logic [1:0] firstResp;
        int         holdOff;
        expResp = (addr < 8'd128) ? okayResp : slvErrResp;
        sendBeats(addr, code, strb);
        awaitResponse();
        checkValue("write response", expResp, axiResp.bresp);
        firstResp = axiResp.bresp;
        if (expResp == okayResp && strb[0])
        begin
            prevCode[addr[6:2]] = shadow[addr[6:2]];
            shadow[addr[6:2]]   = code;
            grace[addr[6:2]]    = 1;
        end
        holdOff = nextRandom() & 3;     // back-pressure on the response
        repeat (holdOff)
        begin
            @(negedge clk);
            checkValue("bvalid held", 1, axiResp.bvalid);
            checkValue("bresp held", firstResp, axiResp.bresp);
            checkValue("awready while response pending", 0, axiResp.awready);
            checkValue("wready while response pending", 0, axiResp.wready);
        end
        axiReq.bready = 1'b1;
        @(negedge clk);
        axiReq.bready = 1'b0;
        checkValue("bvalid after bready", 0, axiResp.bvalid);
    endtask

    task automatic waitStrobes(input int target);
        int cycles;
        cycles = 0;
        while (strobeIdx < target)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 8000)
            begin
                stopOnError("refresh did not reach the expected strobe count");
            end
        end
    endtask

    initial
    begin
        int cycles;
        int base;
        axiReq  = '0;
        lcdOnIn = 1'b0;
        for (int i = 0; i < 32; i++)
        begin
            shadow[i]   = 8'h00;
            prevCode[i] = 8'h00;
            grace[i]    = 0;
        end
        repeat (4) @(negedge clk);
        lcdOnIn = 1'b1;

        // fill every position ahead of the first refresh pass
        for (int p = 0; p < 32; p++)
        begin
            writeChar({1'b0, 5'(p), 2'(nextRandom())}, 8'(nextRandom()),
                      {1'(nextRandom()), 1'b1});
        end
        writeChar(8'h80 | 8'(nextRandom()), 8'(nextRandom()), 2'b11);   // out of range
        writeChar({1'b0, 5'(nextRandom()), 2'b00}, 8'(nextRandom()), 2'b10);
        waitStrobes(8 + 128);

        // rewrites to distinct positions while the refresh runs
        base = nextRandom() & 31;
        for (int k = 0; k < 8; k++)
        begin
            writeChar({1'b0, 5'(base + 4 * k), 2'b00}, 8'(nextRandom()), 2'b01);
        end
        waitStrobes(strobeIdx + 192);

        // reset in the middle of a strobe with a response pending
        sendBeats({1'b0, 5'(nextRandom()), 2'b00}, 8'(nextRandom()), 2'b00);
        awaitResponse();
        checkValue("bresp before reset", okayResp, axiResp.bresp);
        cycles = 0;
        while (!lcdPins.en)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 100)
            begin
                stopOnError("no LCD strobe seen before the mid-refresh reset");
            end
        end
        lcdOnIn = 1'b0;
        @(negedge clk);
        checkValue("en in reset", 0, lcdPins.en);
        checkValue("bvalid in reset", 0, axiResp.bvalid);
        repeat (3) @(negedge clk);
        lcdOnIn = 1'b1;
        waitStrobes(8 + 64);    // init sequence again and one pass

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/lcdPkg.sv
src/hostPkg.sv
src/charWriteSlave.sv
src/charBuffer.sv
src/lcdSequencer.sv
src/lcdBusCycle.sv
src/lcdController.sv
sim/tbClock.sv
sim/lcdController_assertions.sv
sim/lcdControllerTb.sv
